// ==== cpld_ram512k.f ====
+incdir+include
verilog/ram_exp_pkg.sv
verilog/bus_cycle_sampler.sv
verilog/bank_config_regs.sv
verilog/bank_mapper.sv
verilog/cpld_ram512k.sv
sim/cpld_ram512k_tb.sv

// ==== include/ram_map_model.svh ====
// Reference model of the RAM expansion block mapping
// Expected chip select, RAM disable, high address and output enable

`ifndef RAM_MAP_MODEL_SVH
`define RAM_MAP_MODEL_SVH

// True when the scheme claims the block, adr15 is assumed stable over the cycle
function automatic logic model_hit(ram_exp_pkg::scheme_t scheme, ram_exp_pkg::block_t blk);
  logic hit;
  case (scheme)
    3'b000:                 hit = 1'b0;
    3'b001:                 hit = (blk == ram_exp_pkg::BLOCK_TOP);
    3'b010:                 hit = 1'b1;
    ram_exp_pkg::SCHEME_C3: hit = (blk == ram_exp_pkg::BLOCK_TOP);
    default:                hit = (blk == ram_exp_pkg::BLOCK_ONE);
  endcase
  return hit;
endfunction

// Bank plus the block of that bank that the access lands in
function automatic ram_exp_pkg::ram_adr_hi_t model_adr_hi(ram_exp_pkg::bank_t bank,
                                                          ram_exp_pkg::scheme_t scheme,
                                                          ram_exp_pkg::block_t blk);
  ram_exp_pkg::block_t map_blk;
  if (scheme == 3'b010) map_blk = blk;
  else if (scheme[2]) map_blk = scheme[1:0];
  else map_blk = ram_exp_pkg::BLOCK_TOP;
  return {bank, map_blk};
endfunction

// Internal RAM disable for a claimed access
function automatic logic model_ramdis(logic card_sel, ram_exp_pkg::scheme_t scheme,
                                      ram_exp_pkg::block_t blk);
  return card_sel && model_hit(scheme, blk);
endfunction

// SRAM chip select, active low during a mapped memory cycle
function automatic logic model_ramcs_b(logic card_sel, ram_exp_pkg::scheme_t scheme,
                                       ram_exp_pkg::block_t blk, logic mreq_b, logic rfsh_b);
  return !(model_ramdis(card_sel, scheme, blk) && !mreq_b && rfsh_b);
endfunction

// SRAM output enable following the ROM overlay rule
function automatic logic model_ramoe_b(ram_exp_pkg::block_t blk, logic urom_disable,
                                       logic lrom_disable, logic mreq_b, logic rfsh_b,
                                       logic rd_b);
  logic ramrd;
  ramrd = rfsh_b && !mreq_b &&
          ((blk[1] != blk[0]) ||
           (urom_disable && (blk == ram_exp_pkg::BLOCK_TOP)) ||
           (lrom_disable && (blk == ram_exp_pkg::BLOCK_LOW)));
  return !ramrd || rd_b;
endfunction

`endif

// ==== sim/cpld_ram512k_tb.sv ====
// Testbench for the 512K RAM expansion CPLD
// Directed bank, ROM and port tests plus random traffic against a reference model

`timescale 1ns/1ps

module cpld_ram512k_tb;

  localparam int TIMEOUT_CYCLES = 4000;  // Tests need about 400 cycles

  logic clk, reset_b, rfsh_b, adr15, adr14, adr8, iorq_b, mreq_b, wr_b, rd_b;
  ram_exp_pkg::cpu_data_t   data;
  ram_exp_pkg::ram_adr_hi_t ramadrhi;
  logic ramcs_b, ramoe_b, ramwe_b, ramdis;

  // Expected register state of the card
  ram_exp_pkg::bank_t   ref_bank;
  ram_exp_pkg::scheme_t ref_scheme;
  logic ref_card_sel, ref_urom, ref_lrom;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] rnd;

  `include "ram_map_model.svh"

  cpld_ram512k dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                       input string message);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, message, actual, expected);
    end
  endtask

  // One I/O write held for a full clock, starting 2 ns after a rising edge
  task automatic io_write(input logic port_a8, input ram_exp_pkg::cpu_data_t value,
                          input logic a15);
    adr15  = a15;
    adr8   = port_a8;
    data   = value;
    iorq_b = 1'b0;
    wr_b   = 1'b0;
    @(posedge clk);
    #2;
    iorq_b = 1'b1;
    wr_b   = 1'b1;
    adr15  = 1'b0;
    if (!a15 && value[7:6] == ram_exp_pkg::CTRL_RAM_SEL) begin
      ref_bank     = value[5:3];
      ref_scheme   = value[2:0];
      ref_card_sel = port_a8;        // Only port 7Fxx selects this card
    end else if (!a15 && value[7:6] == ram_exp_pkg::CTRL_ROM_SEL) begin
      ref_urom = value[3];
      ref_lrom = value[2];
    end
  endtask

  // Address phase with mreq_b high, then one cycle with mreq_b low; rd low reads, else writes
  task automatic mem_access(input logic a15, input logic a14, input logic rd, input logic rfsh);
    ram_exp_pkg::block_t blk;
    logic exp_cs_b;
    string tag;
    blk   = {a15, a14};
    adr15 = a15;
    adr14 = a14;
    @(posedge clk);
    #2;
    mreq_b = 1'b0;
    rfsh_b = rfsh;
    rd_b   = rd;
    wr_b   = !(rd && rfsh);         // A refresh neither reads nor writes
    @(negedge clk);
    #2;
    tag = $sformatf("scheme %0d bank %0d block %0d rd_b %0b rfsh_b %0b",
                    ref_scheme, ref_bank, blk, rd, rfsh);
    exp_cs_b = model_ramcs_b(ref_card_sel, ref_scheme, blk, 1'b0, rfsh);
    check(ramcs_b, exp_cs_b, {"ramcs_b ", tag});
    check(ramdis, model_ramdis(ref_card_sel, ref_scheme, blk), {"ramdis ", tag});
    check(ramoe_b, model_ramoe_b(blk, ref_urom, ref_lrom, 1'b0, rfsh, rd), {"ramoe_b ", tag});
    check(ramwe_b, wr_b, {"ramwe_b ", tag});
    if (!exp_cs_b) check(ramadrhi, model_adr_hi(ref_bank, ref_scheme, blk), {"ramadrhi ", tag});
    @(posedge clk);
    #2;
    mreq_b = 1'b1;
    rfsh_b = 1'b1;
    rd_b   = 1'b1;
    wr_b   = 1'b1;
  endtask

  task automatic all_blocks(input logic rd, input logic rfsh);
    for (int b = 0; b < 4; b++) mem_access(b[1], b[0], rd, rfsh);
  endtask

  task automatic reset_state_accesses();
    all_blocks(1'b0, 1'b1);   // Card deselected, ROM flags clear
    all_blocks(1'b1, 1'b1);
  endtask

  task automatic scheme_sweep();
    for (int s = 0; s < 8; s++) begin
      io_write(1'b1, {ram_exp_pkg::CTRL_RAM_SEL, 3'd2, 3'(s)}, 1'b0);
      all_blocks(1'b0, 1'b1);
      io_write(1'b1, {ram_exp_pkg::CTRL_RAM_SEL, 3'd5, 3'(s)}, 1'b0);
      all_blocks(1'b1, 1'b1);
    end
  endtask

  task automatic card_select_port();
    io_write(1'b0, {ram_exp_pkg::CTRL_RAM_SEL, 3'd6, 3'd2}, 1'b0);  // Port 7Exx
    all_blocks(1'b0, 1'b1);
    io_write(1'b1, {ram_exp_pkg::CTRL_RAM_SEL, 3'd6, 3'd2}, 1'b0);
    all_blocks(1'b0, 1'b1);
  endtask

  task automatic rom_flag_combos();
    for (int f = 0; f < 4; f++) begin
      io_write(1'b1, {ram_exp_pkg::CTRL_ROM_SEL, 2'b00, 2'(f), 2'b01}, 1'b0);
      all_blocks(1'b0, 1'b1);
      all_blocks(1'b1, 1'b1);
      all_blocks(1'b1, 1'b0);   // Refresh cycles
    end
  endtask

  task automatic adr15_write_ignored();
    io_write(1'b1, {ram_exp_pkg::CTRL_RAM_SEL, 3'd1, 3'd7}, 1'b1);
    // Both ROM flags are set at this point, so a taken write would clear them
    io_write(1'b1, {ram_exp_pkg::CTRL_ROM_SEL, 6'b000000}, 1'b1);
    all_blocks(1'b0, 1'b1);
  endtask

  task automatic random_traffic();
    for (int i = 0; i < 40; i++) begin
      rnd = $urandom;
      if (rnd[11]) io_write(rnd[8], {1'b1, rnd[7], rnd[5:0]}, rnd[10:9] == 2'b00);
      else mem_access(rnd[0], rnd[1], rnd[2], rnd[4:3] != 2'b00);
    end
  endtask

  initial begin
    rnd = $urandom(32'h7897846b);
    {reset_b, adr15, adr14, adr8, data} = '0;
    {rfsh_b, iorq_b, mreq_b, wr_b, rd_b} = '1;
    {ref_bank, ref_scheme, ref_card_sel, ref_urom, ref_lrom} = '0;
    repeat (10) @(posedge clk);
    #2;
    reset_b = 1'b1;
    repeat (3) @(posedge clk);   // Let the reset synchronizer release
    #2;
    check(ramcs_b, 1'b1, "ramcs_b idle after reset");
    check(ramoe_b, 1'b1, "ramoe_b idle after reset");
    check(ramdis, 1'b0, "ramdis idle after reset");
    reset_state_accesses();
    scheme_sweep();
    card_select_port();
    rom_flag_combos();
    adr15_write_ignored();
    random_traffic();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verilog/bank_config_regs.sv ====
// Control port registers of the RAM expansion
// Decodes writes to the gate array port and holds bank, scheme, card select and ROM flags

`timescale 1ns/1ps

module bank_config_regs (
  input  logic                  clk,
  input  logic                  sync_reset_b,
  input  logic                  iorq_b,
  input  logic                  wr_b,
  input  logic                  adr15,
  input  logic                  adr8,
  input  ram_exp_pkg::cpu_data_t data,
  output ram_exp_pkg::bank_t     bank,
  output ram_exp_pkg::scheme_t   scheme,
  output logic                  card_sel,
  output logic                  urom_disable,
  output logic                  lrom_disable
);

  logic io_wr_ctrl;    // I/O write to the port decoded by A15 low
  logic ram_ctrl_sel;  // Bank-select write
  logic rom_ctrl_sel;  // ROM-control write

  // The gate array and the expansion share the port, only A15 is decoded
  assign io_wr_ctrl   = !iorq_b && !wr_b && !adr15;

  // Function code sits in the top two data bits
  assign ram_ctrl_sel = io_wr_ctrl && (data[7:6] == ram_exp_pkg::CTRL_RAM_SEL);
  assign rom_ctrl_sel = io_wr_ctrl && (data[7:6] == ram_exp_pkg::CTRL_ROM_SEL);

  // Registers change on the falling edge, mid way through the IOREQ write
  always_ff @(negedge clk or negedge sync_reset_b) begin
    if (!sync_reset_b) begin
      bank         <= '0;
      scheme       <= '0;
      card_sel     <= 1'b0;   // Card starts deselected, CPC sees only its own RAM
      urom_disable <= 1'b0;
      lrom_disable <= 1'b0;
    end else if (ram_ctrl_sel) begin
      bank     <= data[5:3];  // Which 64K of the 512K
      scheme   <= data[2:0];  // How the 16K blocks are switched
      // Port 7Fxx claims the write for this card and 7Exx hands it to a
      // second expansion, so A8 alone decides the selection
      card_sel <= adr8;
    end else if (rom_ctrl_sel) begin
      urom_disable <= data[3];
      lrom_disable <= data[2];  // Screen mode bits 1..0 are left to the gate array
    end
  end

  // The two function codes differ in data bit 6 so one write can never
  // update both register groups
  a_ctrl_exclusive: assert property (
    @(negedge clk) disable iff (!sync_reset_b)
      !(ram_ctrl_sel && rom_ctrl_sel)
  ) else $error("RAM and ROM control decodes active together");

endmodule

// ==== verilog/bank_mapper.sv ====
// Block mapper of the RAM expansion
// Turns the bank configuration and the CPU address into SRAM selects and high address
// Also works out locally whether a read goes to RAM or is overlaid by ROM

`timescale 1ns/1ps

module bank_mapper (
  input  logic                      rfsh_b,
  input  logic                      mreq_b,
  input  logic                      rd_b,
  input  logic                      adr15,
  input  logic                      adr14,
  input  logic                      adr15_lat,
  input  logic                      card_sel,
  input  logic                      urom_disable,
  input  logic                      lrom_disable,
  input  ram_exp_pkg::bank_t         bank,
  input  ram_exp_pkg::scheme_t       scheme,
  output ram_exp_pkg::ram_adr_hi_t   ramadrhi,
  output logic                      ramcs_b,
  output logic                      ramoe_b,
  output logic                      ramdis
);

  ram_exp_pkg::block_t cur_block;   // Block of the live address
  ram_exp_pkg::block_t lat_block;   // Block with A15 held from the address phase
  ram_exp_pkg::block_t map_block;   // Block of the chosen bank that is accessed
  logic                hit;         // Scheme claims this block
  logic                mapped;      // Access goes to the expansion RAM
  logic                mem_cycle;   // Real memory access, not a refresh
  logic                int_ramrd;   // Read is served by RAM rather than ROM

  assign cur_block = {adr15, adr14};
  assign lat_block = {adr15_lat, adr14};

  // Scheme decode following the DK'Tronics and 6128 banking table
  always_comb begin
    hit       = 1'b0;
    map_block = cur_block;
    case (scheme)
      3'b000: begin
        hit = 1'b0;                                    // Base 64K only
      end
      3'b001: begin
        hit       = (cur_block == ram_exp_pkg::BLOCK_TOP);
        map_block = ram_exp_pkg::BLOCK_TOP;             // Only 0xC000 is swapped
      end
      3'b010: begin
        hit       = 1'b1;                              // All four blocks from the bank
        map_block = cur_block;
      end
      ram_exp_pkg::SCHEME_C3: begin
        // Held A15 keeps the decision steady for the whole cycle
        hit       = (lat_block == ram_exp_pkg::BLOCK_TOP);
        map_block = ram_exp_pkg::BLOCK_TOP;
      end
      default: begin
        // Schemes 4 to 7 put one bank block into the 0x4000 window
        hit       = (cur_block == ram_exp_pkg::BLOCK_ONE);
        map_block = scheme[1:0];
      end
    endcase
  end

  assign mapped    = hit && card_sel;
  assign mem_cycle = !mreq_b && rfsh_b;

  // Internal RAM is held off for every access the card owns
  assign ramdis   = mapped;
  assign ramcs_b  = !(mapped && mem_cycle);
  assign ramadrhi = {bank, map_block};   // Only meaningful while ramcs_b is low

  // The middle 32K is never under ROM. Block 0 and block 3 read RAM only when
  // their ROM is switched off
  always_comb begin
    int_ramrd = 1'b0;
    if (mem_cycle) begin
      if (adr15_lat != adr14) begin
        int_ramrd = 1'b1;
      end else if (urom_disable && (cur_block == ram_exp_pkg::BLOCK_TOP)) begin
        int_ramrd = 1'b1;
      end else if (lrom_disable && (cur_block == ram_exp_pkg::BLOCK_LOW)) begin
        int_ramrd = 1'b1;
      end
    end
  end

  assign ramoe_b = !int_ramrd || rd_b;   // Output enable needs a CPU read as well

  // When the SRAM chip select ends, internal RAM must have been disabled up
  // to that point, otherwise both memories drove the bus together
  a_cs_needs_ramdis: assert property (
    @(posedge ramcs_b) !ramcs_b |-> ramdis
  ) else $error("ramcs_b was low without ramdis high");

endmodule

// ==== verilog/bus_cycle_sampler.sv ====
// Bus cycle sampler for the RAM expansion
// Releases reset in step with clk, samples MREQ and holds A15 for each memory cycle

`timescale 1ns/1ps

module bus_cycle_sampler (
  input  logic clk,
  input  logic reset_b,
  input  logic mreq_b,
  input  logic adr15,
  output logic sync_reset_b,
  output logic adr15_lat
);

  logic [1:0] reset_pipe;   // Two stage release pipeline
  logic       mreq_b_q;     // MREQ as seen on the last rising edge

  // Reset asserts at once and is released on the second rising edge
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      reset_pipe <= 2'b00;
    end else begin
      reset_pipe <= {reset_pipe[0], 1'b1};  // Shift in the released level
    end
  end

  assign sync_reset_b = reset_pipe[1];

  // An idle bus reads as MREQ high
  always_ff @(posedge clk or negedge sync_reset_b) begin
    if (!sync_reset_b) begin
      mreq_b_q <= 1'b1;
    end else begin
      mreq_b_q <= mreq_b;
    end
  end

  // A15 is captured on falling edges of the address phase only, which gives
  // a value that cannot move once the gate array has seen MREQ go low
  always_ff @(negedge clk or negedge sync_reset_b) begin
    if (!sync_reset_b) begin
      adr15_lat <= 1'b0;
    end else if (mreq_b_q) begin
      adr15_lat <= adr15;  // Track the address until the cycle starts
    end
  end

  // Once the sampled MREQ is low the held A15 must not change before the
  // next rising edge, across the falling edge in between
  a_adr15_held: assert property (
    @(posedge clk) disable iff (!sync_reset_b)
      !mreq_b_q |-> $stable(adr15_lat)
  ) else $error("adr15_lat moved during the low phase of mreq_b");

endmodule

// ==== verilog/cpld_ram512k.sv ====
// Top level of the 512K RAM expansion CPLD for the CPC 6128
// Connects the bus sampler, the control registers and the block mapper

`timescale 1ns/1ps

module cpld_ram512k (
  input  logic                      clk,
  input  logic                      reset_b,
  input  logic                      rfsh_b,
  input  logic                      adr15,
  input  logic                      adr14,
  input  logic                      adr8,
  input  logic                      iorq_b,
  input  logic                      mreq_b,
  input  logic                      wr_b,
  input  logic                      rd_b,
  input  ram_exp_pkg::cpu_data_t     data,
  output ram_exp_pkg::ram_adr_hi_t   ramadrhi,
  output logic                      ramcs_b,
  output logic                      ramoe_b,
  output logic                      ramwe_b,
  output logic                      ramdis
);

  logic                 sync_reset_b;   // Reset released in step with clk
  logic                 adr15_lat;      // A15 held over the memory cycle
  ram_exp_pkg::bank_t   bank;
  ram_exp_pkg::scheme_t scheme;
  logic                 card_sel;
  logic                 urom_disable;
  logic                 lrom_disable;

  bus_cycle_sampler sampler_i (
    .clk          (clk),
    .reset_b      (reset_b),
    .mreq_b       (mreq_b),
    .adr15        (adr15),
    .sync_reset_b (sync_reset_b),
    .adr15_lat    (adr15_lat)
  );

  bank_config_regs config_i (
    .clk          (clk),
    .sync_reset_b (sync_reset_b),
    .iorq_b       (iorq_b),
    .wr_b         (wr_b),
    .adr15        (adr15),
    .adr8         (adr8),
    .data         (data),
    .bank         (bank),
    .scheme       (scheme),
    .card_sel     (card_sel),
    .urom_disable (urom_disable),
    .lrom_disable (lrom_disable)
  );

  bank_mapper mapper_i (
    .rfsh_b       (rfsh_b),
    .mreq_b       (mreq_b),
    .rd_b         (rd_b),
    .adr15        (adr15),
    .adr14        (adr14),
    .adr15_lat    (adr15_lat),
    .card_sel     (card_sel),
    .urom_disable (urom_disable),
    .lrom_disable (lrom_disable),
    .bank         (bank),
    .scheme       (scheme),
    .ramadrhi     (ramadrhi),
    .ramcs_b      (ramcs_b),
    .ramoe_b      (ramoe_b),
    .ramdis       (ramdis)
  );

  assign ramwe_b = wr_b;   // Chip select gates writes, so the CPU strobe goes straight through

endmodule

// ==== verilog/ram_exp_pkg.sv ====
// Shared definitions for the 512K RAM expansion CPLD
// Bus widths, register field types and the control port codes

package ram_exp_pkg;

  // Field widths
  localparam int DATA_W   = 8;                   // Z80 data bus
  localparam int BANK_W   = 3;                   // Eight 64K banks make up the 512K
  localparam int SCHEME_W = 3;                   // Eight block switching schemes
  localparam int BLOCK_W  = 2;                   // Four 16K blocks per 64K bank
  localparam int ADR_HI_W = BANK_W + BLOCK_W;    // SRAM address bits above A13

  // Value on the CPU data bus
  typedef logic [DATA_W-1:0]   cpu_data_t;

  // Selected 64K bank inside the expansion RAM
  typedef logic [BANK_W-1:0]   bank_t;

  // Block switching scheme from the low bits of a bank-select write
  typedef logic [SCHEME_W-1:0] scheme_t;

  // 16K block number, always formed as {A15, A14}
  typedef logic [BLOCK_W-1:0]  block_t;

  // High SRAM address, bank in the upper bits and block in the lower bits
  typedef logic [ADR_HI_W-1:0] ram_adr_hi_t;

  // Data bits 7..6 of an I/O write to the gate array port select the function
  localparam logic [1:0] CTRL_RAM_SEL = 2'b11;   // Bank and scheme select
  localparam logic [1:0] CTRL_ROM_SEL = 2'b10;   // Mode and ROM enable register

  // Scheme 3 maps the 0x4000 window to block 3 but keeps the CPU's view of
  // 0xC000 as well, so it is decoded from the A15 value held over the cycle
  localparam scheme_t SCHEME_C3 = 3'b011;

  // Named blocks of the 64K CPU map
  localparam block_t BLOCK_LOW = 2'b00;          // 0x0000 to 0x3FFF, shared with lower ROM
  localparam block_t BLOCK_ONE = 2'b01;          // 0x4000 to 0x7FFF, the switchable window
  localparam block_t BLOCK_TOP = 2'b11;          // 0xC000 to 0xFFFF, shared with upper ROM

endpackage
